//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Data path width, one MIPS word
`define CACHE_DATA_W 32

// Word address split into tag, index and word offset
`define CACHE_TAG_W 10
`define CACHE_INDEX_W 9 // 512 lines
`define CACHE_OFFSET_W 2 // Word within a line

// Full word address, 21 bits
`define CACHE_ADDR_W (`CACHE_TAG_W + `CACHE_INDEX_W + `CACHE_OFFSET_W)

// Line geometry
`define CACHE_WORDS (1 << `CACHE_OFFSET_W) // Four words per line

`endif

//--- src/cache_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

	// Processor request into either cache
	// I-side ignores read_write_n and wdata
	typedef struct packed {
		logic valid;
		logic read_write_n; // 1 read, 0 write
		logic [`CACHE_ADDR_W-1:0] addr; // Word address {tag, index, offset}
		logic [`CACHE_DATA_W-1:0] wdata;
	} cache_req_t;

	// Result back to the processor
	typedef struct packed {
		logic ready; // Level, request taken when valid && ready
		logic valid; // One-cycle pulse per request
		logic [`CACHE_DATA_W-1:0] rdata;
	} cache_rsp_t;

	// Line transfer request toward memory
	typedef struct packed {
		logic valid; // Held for the whole transfer
		logic read_write_n;
		logic [`CACHE_ADDR_W-1:0] addr; // Line start, offset bits zero
		logic [`CACHE_DATA_W-1:0] wdata; // Current write-out word
	} mem_req_t;

	// Memory response, one word per beat
	typedef struct packed {
		logic valid; // Read beat
		logic data_read; // Write word taken
		logic last; // Fourth beat of either kind
		logic [`CACHE_DATA_W-1:0] rdata;
	} mem_rsp_t;

	// Tag store word
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag;
		logic valid;
		logic dirty;
	} line_state_t;

endpackage

`default_nettype wire

//--- src/cache_sram.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_macros.svh"

// Single-port RAM, one address for read and write
module cache_sram #(
	parameter type T = logic [`CACHE_DATA_W-1:0], // Stored word
	parameter int ADDR_W = `CACHE_INDEX_W
) (
	input wire i_Clk,
	input wire [ADDR_W-1:0] i_Addr,
	input wire i_Write_Enable,
	input wire T i_Write_Data,
	output T o_Read_Data
);

	T mem [0:(1<<ADDR_W)-1];

	always_ff @(posedge i_Clk) begin
		if (i_Write_Enable)
			mem[i_Addr] <= i_Write_Data;
		o_Read_Data <= mem[i_Addr]; // Registered read, old data on a write
	end

endmodule

`default_nettype wire

//--- src/d_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_macros.svh"

// Direct-mapped write-back, write-allocate data cache
module d_cache (
	input wire i_Clk,
	input wire i_Reset_n,
	input wire cache_pkg::cache_req_t i_Req,
	output cache_pkg::cache_rsp_t o_Rsp,
	output cache_pkg::mem_req_t o_Mem_Req,
	input wire cache_pkg::mem_rsp_t i_Mem_Rsp
);

	localparam int OFF_W = `CACHE_OFFSET_W;

	typedef enum logic [2:0] {
		ST_SWEEP, // Clearing tag store after reset
		ST_READY,
		ST_WRITEOUT, // Dirty victim to memory
		ST_POPULATE, // Line fill
		ST_PAUSE // Miss result cycle
	} state_t;

	state_t state;
	logic pend; // Lookup cycle after acceptance
	logic [`CACHE_INDEX_W-1:0] sweep_idx;
	logic [`CACHE_OFFSET_W-1:0] word_cnt; // Beat within the transfer
	cache_pkg::cache_req_t r_req; // Saved request
	logic [`CACHE_DATA_W-1:0] r_rdata; // Requested word from the fill
	logic mem_valid;
	logic mem_rw_n;
	logic [`CACHE_ADDR_W-1:0] mem_addr;

	logic [`CACHE_INDEX_W-1:0] req_idx;
	logic [`CACHE_INDEX_W-1:0] r_idx;
	logic [`CACHE_OFFSET_W-1:0] r_off;
	logic [`CACHE_TAG_W-1:0] r_tag;

	logic [`CACHE_INDEX_W-1:0] sram_idx;
	logic [`CACHE_WORDS-1:0] bank_we;
	logic [`CACHE_DATA_W-1:0] bank_wdata;
	logic [`CACHE_DATA_W-1:0] bank_q [`CACHE_WORDS];
	logic ts_we;
	cache_pkg::line_state_t ts_wdata;
	cache_pkg::line_state_t ts_q;

	logic can_accept;
	logic accept;
	logic hit;
	logic write_hit;
	logic fill_beat;
	logic [`CACHE_DATA_W-1:0] fill_data;

	// Address fields
	assign req_idx = i_Req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign r_idx = r_req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign r_off = r_req.addr[`CACHE_OFFSET_W-1:0];
	assign r_tag = r_req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

	// PAUSE also takes a request, the result goes out there
	assign can_accept = (state == ST_READY && !pend) || state == ST_PAUSE;
	assign accept = can_accept && i_Req.valid;
	assign hit = pend && ts_q.valid && (ts_q.tag == r_tag); // Registered tag word
	assign write_hit = hit && !r_req.read_write_n;
	assign fill_beat = (state == ST_POPULATE) && i_Mem_Rsp.valid;
	// Store miss merges its word into the fill
	assign fill_data = (!r_req.read_write_n && word_cnt == r_off) ?
		r_req.wdata : i_Mem_Rsp.rdata;

	// Stores see the request index only while a request can be taken
	always_comb begin
		if (state == ST_SWEEP)
			sram_idx = sweep_idx;
		else if (can_accept)
			sram_idx = req_idx;
		else
			sram_idx = r_idx;
	end

	assign bank_wdata = fill_beat ? fill_data : r_req.wdata;

	for (genvar g = 0; g < `CACHE_WORDS; g++) begin : g_bank
		assign bank_we[g] = (write_hit && r_off == OFF_W'(g)) ||
			(fill_beat && word_cnt == OFF_W'(g));

		cache_sram #(
			.T(logic [`CACHE_DATA_W-1:0]),
			.ADDR_W(`CACHE_INDEX_W)
		) u_bank (
			.i_Clk(i_Clk),
			.i_Addr(sram_idx),
			.i_Write_Enable(bank_we[g]),
			.i_Write_Data(bank_wdata),
			.o_Read_Data(bank_q[g])
		);
	end

	// Tag store updates
	always_comb begin
		ts_we = 1'b0;
		ts_wdata = ts_q;
		if (state == ST_SWEEP) begin
			ts_we = 1'b1;
			ts_wdata = '0; // Invalid, clean
		end else if (write_hit) begin
			ts_we = 1'b1;
			ts_wdata.dirty = 1'b1;
		end else if (state == ST_WRITEOUT && i_Mem_Rsp.data_read && i_Mem_Rsp.last) begin
			ts_we = 1'b1;
			ts_wdata.dirty = 1'b0; // Victim now clean in memory
		end else if (fill_beat && i_Mem_Rsp.last) begin
			ts_we = 1'b1;
			ts_wdata.tag = r_tag;
			ts_wdata.valid = 1'b1;
			ts_wdata.dirty = !r_req.read_write_n; // Store fill is dirty
		end
	end

	cache_sram #(
		.T(cache_pkg::line_state_t),
		.ADDR_W(`CACHE_INDEX_W)
	) u_tag_store (
		.i_Clk(i_Clk),
		.i_Addr(sram_idx),
		.i_Write_Enable(ts_we),
		.i_Write_Data(ts_wdata),
		.o_Read_Data(ts_q)
	);

	assign o_Rsp.ready = can_accept;
	assign o_Rsp.valid = hit || state == ST_PAUSE;
	assign o_Rsp.rdata = (state == ST_PAUSE) ? r_rdata : bank_q[r_off];

	always_comb begin
		o_Mem_Req.valid = mem_valid;
		o_Mem_Req.read_write_n = mem_rw_n;
		o_Mem_Req.addr = mem_addr;
		o_Mem_Req.wdata = bank_q[word_cnt]; // Banks hold the victim line during write-out
	end

	always_ff @(posedge i_Clk or negedge i_Reset_n) begin
		if (!i_Reset_n) begin
			state <= ST_SWEEP;
			pend <= 1'b0;
			sweep_idx <= '0;
			word_cnt <= '0;
			mem_valid <= 1'b0;
			mem_rw_n <= 1'b1;
			mem_addr <= '0;
		end else begin
			case (state)
				ST_SWEEP: begin
					sweep_idx <= sweep_idx + 1'b1;
					if (&sweep_idx)
						state <= ST_READY;
				end
				ST_READY: begin
					if (pend) begin
						pend <= 1'b0;
						if (!hit) begin
							mem_valid <= 1'b1;
							word_cnt <= '0;
							if (ts_q.valid && ts_q.dirty) begin
								state <= ST_WRITEOUT;
								mem_rw_n <= 1'b0;
								mem_addr <= {ts_q.tag, r_idx, {`CACHE_OFFSET_W{1'b0}}};
							end else begin
								state <= ST_POPULATE;
								mem_rw_n <= 1'b1;
								mem_addr <= {r_tag, r_idx, {`CACHE_OFFSET_W{1'b0}}};
							end
						end
					end else if (accept) begin
						pend <= 1'b1;
					end
				end
				ST_WRITEOUT: begin
					if (i_Mem_Rsp.data_read) begin
						word_cnt <= word_cnt + 1'b1; // Wraps to zero on the last word
						if (i_Mem_Rsp.last) begin
							state <= ST_POPULATE; // mem valid stays high
							mem_rw_n <= 1'b1;
							mem_addr <= {r_tag, r_idx, {`CACHE_OFFSET_W{1'b0}}};
						end
					end
				end
				ST_POPULATE: begin
					if (i_Mem_Rsp.valid) begin
						word_cnt <= word_cnt + 1'b1;
						if (i_Mem_Rsp.last) begin
							mem_valid <= 1'b0;
							state <= ST_PAUSE;
						end
					end
				end
				ST_PAUSE: begin
					state <= ST_READY;
					pend <= accept;
				end
				default: state <= ST_SWEEP;
			endcase
		end
	end

	// Request and returned word
	always_ff @(posedge i_Clk) begin
		if (accept)
			r_req <= i_Req;
		if (fill_beat && word_cnt == r_off)
			r_rdata <= fill_data;
	end

endmodule

`default_nettype wire

//--- src/i_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_macros.svh"

// Direct-mapped read-only instruction cache
module i_cache (
	input wire i_Clk,
	input wire i_Reset_n,
	input wire cache_pkg::cache_req_t i_Req,
	output cache_pkg::cache_rsp_t o_Rsp,
	output cache_pkg::mem_req_t o_Mem_Req,
	input wire cache_pkg::mem_rsp_t i_Mem_Rsp
);

	localparam int OFF_W = `CACHE_OFFSET_W;

	typedef enum logic [1:0] {
		ST_SWEEP,
		ST_READY,
		ST_POPULATE,
		ST_PAUSE
	} state_t;

	state_t state;
	logic pend; // Lookup in progress
	logic [`CACHE_INDEX_W-1:0] sweep_idx;
	logic [`CACHE_OFFSET_W-1:0] word_cnt;
	logic [`CACHE_ADDR_W-1:0] r_addr; // Fetch address
	logic [`CACHE_DATA_W-1:0] r_rdata;
	logic mem_valid;
	logic [`CACHE_ADDR_W-1:0] mem_addr;

	logic [`CACHE_INDEX_W-1:0] r_idx;
	logic [`CACHE_OFFSET_W-1:0] r_off;
	logic [`CACHE_TAG_W-1:0] r_tag;
	logic [`CACHE_INDEX_W-1:0] sram_idx;
	logic [`CACHE_DATA_W-1:0] bank_q [`CACHE_WORDS];
	cache_pkg::line_state_t ts_wdata;
	cache_pkg::line_state_t ts_q;
	logic can_accept;
	logic accept;
	logic hit;
	logic fill_beat;

	assign r_idx = r_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign r_off = r_addr[`CACHE_OFFSET_W-1:0];
	assign r_tag = r_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

	assign can_accept = (state == ST_READY && !pend) || state == ST_PAUSE;
	assign accept = can_accept && i_Req.valid;
	assign hit = pend && ts_q.valid && (ts_q.tag == r_tag);
	assign fill_beat = (state == ST_POPULATE) && i_Mem_Rsp.valid;

	assign sram_idx = (state == ST_SWEEP) ? sweep_idx :
		can_accept ? i_Req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : r_idx;

	for (genvar g = 0; g < `CACHE_WORDS; g++) begin : g_bank
		cache_sram #(
			.T(logic [`CACHE_DATA_W-1:0]),
			.ADDR_W(`CACHE_INDEX_W)
		) u_bank (
			.i_Clk(i_Clk),
			.i_Addr(sram_idx),
			.i_Write_Enable(fill_beat && word_cnt == OFF_W'(g)), // Fill only
			.i_Write_Data(i_Mem_Rsp.rdata),
			.o_Read_Data(bank_q[g])
		);
	end

	// Cleared on sweep, tagged on the last fill beat
	assign ts_wdata = (state == ST_SWEEP) ? '0 : '{tag: r_tag, valid: 1'b1, dirty: 1'b0};

	cache_sram #(
		.T(cache_pkg::line_state_t),
		.ADDR_W(`CACHE_INDEX_W)
	) u_tag_store (
		.i_Clk(i_Clk),
		.i_Addr(sram_idx),
		.i_Write_Enable(state == ST_SWEEP || (fill_beat && i_Mem_Rsp.last)),
		.i_Write_Data(ts_wdata),
		.o_Read_Data(ts_q)
	);

	assign o_Rsp.ready = can_accept;
	assign o_Rsp.valid = hit || state == ST_PAUSE;
	assign o_Rsp.rdata = (state == ST_PAUSE) ? r_rdata : bank_q[r_off];

	// Fetch side only reads
	assign o_Mem_Req = '{valid: mem_valid, read_write_n: 1'b1, addr: mem_addr, wdata: '0};

	always_ff @(posedge i_Clk or negedge i_Reset_n) begin
		if (!i_Reset_n) begin
			state <= ST_SWEEP;
			pend <= 1'b0;
			sweep_idx <= '0;
			word_cnt <= '0;
			mem_valid <= 1'b0;
			mem_addr <= '0;
		end else begin
			case (state)
				ST_SWEEP: begin
					sweep_idx <= sweep_idx + 1'b1;
					if (&sweep_idx)
						state <= ST_READY;
				end
				ST_READY: begin
					if (pend) begin
						pend <= 1'b0;
						if (!hit) begin // Miss, fetch the line
							state <= ST_POPULATE;
							mem_valid <= 1'b1;
							word_cnt <= '0;
							mem_addr <= {r_tag, r_idx, {`CACHE_OFFSET_W{1'b0}}};
						end
					end else if (accept) begin
						pend <= 1'b1;
					end
				end
				ST_POPULATE: begin
					if (i_Mem_Rsp.valid) begin
						word_cnt <= word_cnt + 1'b1;
						if (i_Mem_Rsp.last) begin
							mem_valid <= 1'b0;
							state <= ST_PAUSE;
						end
					end
				end
				default: begin // ST_PAUSE
					state <= ST_READY;
					pend <= accept;
				end
			endcase
		end
	end

	always_ff @(posedge i_Clk) begin
		if (accept)
			r_addr <= i_Req.addr;
		if (fill_beat && word_cnt == r_off)
			r_rdata <= i_Mem_Rsp.rdata; // Requested word as it streams by
	end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

// Two caches onto one memory port, one whole transfer per grant
module mem_arbiter (
	input wire i_Clk,
	input wire i_Reset_n,
	input wire cache_pkg::mem_req_t i_D_Mem_Req,
	input wire cache_pkg::mem_req_t i_I_Mem_Req,
	output cache_pkg::mem_rsp_t o_D_Mem_Rsp,
	output cache_pkg::mem_rsp_t o_I_Mem_Rsp,
	output cache_pkg::mem_req_t o_Mem_Req,
	input wire cache_pkg::mem_rsp_t i_Mem_Rsp
);

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_D,
		GNT_I
	} grant_t;

	grant_t grant;

	always_ff @(posedge i_Clk or negedge i_Reset_n) begin
		if (!i_Reset_n) begin
			grant <= GNT_NONE;
		end else begin
			case (grant)
				GNT_NONE: begin
					if (i_D_Mem_Req.valid) // Data side has priority
						grant <= GNT_D;
					else if (i_I_Mem_Req.valid)
						grant <= GNT_I;
				end
				GNT_D: begin
					// Write-back plus fill keep valid high, one transfer
					if (!i_D_Mem_Req.valid)
						grant <= GNT_NONE;
				end
				GNT_I: begin
					if (!i_I_Mem_Req.valid)
						grant <= GNT_NONE;
				end
				default: grant <= GNT_NONE;
			endcase
		end
	end

	// Request mux and response steering
	always_comb begin
		o_Mem_Req = '0; // Idle port when nothing is granted
		o_D_Mem_Rsp = '0;
		o_I_Mem_Rsp = '0;
		case (grant)
			GNT_D: begin
				o_Mem_Req = i_D_Mem_Req;
				o_D_Mem_Rsp = i_Mem_Rsp;
			end
			GNT_I: begin
				o_Mem_Req = i_I_Mem_Req;
				o_I_Mem_Rsp = i_Mem_Rsp;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/cache_subsystem_top.sv
`timescale 1ns/100ps
`default_nettype none

// Data and instruction caches sharing one memory port
module cache_subsystem_top (
	input wire i_Clk,
	input wire i_Reset_n,
	input wire cache_pkg::cache_req_t i_D_Req,
	output cache_pkg::cache_rsp_t o_D_Rsp,
	input wire cache_pkg::cache_req_t i_I_Req,
	output cache_pkg::cache_rsp_t o_I_Rsp,
	output cache_pkg::mem_req_t o_Mem_Req,
	input wire cache_pkg::mem_rsp_t i_Mem_Rsp
);

	// Cache to arbiter links
	cache_pkg::mem_req_t d_mem_req;
	cache_pkg::mem_req_t i_mem_req;
	cache_pkg::mem_rsp_t d_mem_rsp;
	cache_pkg::mem_rsp_t i_mem_rsp;

	d_cache u_d_cache (
		.i_Clk(i_Clk),
		.i_Reset_n(i_Reset_n),
		.i_Req(i_D_Req),
		.o_Rsp(o_D_Rsp),
		.o_Mem_Req(d_mem_req),
		.i_Mem_Rsp(d_mem_rsp)
	);

	i_cache u_i_cache (
		.i_Clk(i_Clk),
		.i_Reset_n(i_Reset_n),
		.i_Req(i_I_Req),
		.o_Rsp(o_I_Rsp),
		.o_Mem_Req(i_mem_req),
		.i_Mem_Rsp(i_mem_rsp)
	);

	mem_arbiter u_mem_arbiter (
		.i_Clk(i_Clk),
		.i_Reset_n(i_Reset_n),
		.i_D_Mem_Req(d_mem_req),
		.i_I_Mem_Req(i_mem_req),
		.o_D_Mem_Rsp(d_mem_rsp),
		.o_I_Mem_Rsp(i_mem_rsp),
		.o_Mem_Req(o_Mem_Req), // External memory side
		.i_Mem_Rsp(i_Mem_Rsp)
	);

endmodule

`default_nettype wire

//--- sim/cache_asserts.sv
`timescale 1ns/100ps
`default_nettype none

// Grant and memory port checks on the arbiter
module cache_asserts (
	input wire i_Clk,
	input wire i_Reset_n,
	input wire [1:0] i_Grant, // 0 none, 1 data, 2 instruction
	input wire cache_pkg::mem_req_t i_D_Mem_Req,
	input wire cache_pkg::mem_req_t i_I_Mem_Req,
	input wire cache_pkg::mem_req_t i_Mem_Req,
	input wire cache_pkg::mem_rsp_t i_D_Mem_Rsp,
	input wire cache_pkg::mem_rsp_t i_I_Mem_Rsp
);

	int assert_errors = 0;

	// One owner per transfer, port idles before the grant moves
	a_one_grant: assert property (@(posedge i_Clk) disable iff (!i_Reset_n)
		(i_Mem_Req.valid && $past(i_Mem_Req.valid)) |-> $stable(i_Grant))
	else begin
		assert_errors++;
		$error("Grant moved while the memory port was busy");
	end

	// Write-out to fill changes read_write_n, so only same-direction cycles count
	a_addr_stable: assert property (@(posedge i_Clk) disable iff (!i_Reset_n)
		(i_Mem_Req.valid && $past(i_Mem_Req.valid) && $stable(i_Mem_Req.read_write_n))
		|-> $stable(i_Mem_Req.addr))
	else begin
		assert_errors++;
		$error("Memory address changed during a transfer");
	end

	// Beats reach a cache only while its own request is on the port
	a_d_routed: assert property (@(posedge i_Clk) disable iff (!i_Reset_n)
		(|i_D_Mem_Rsp) |-> (i_D_Mem_Req.valid && i_Mem_Req == i_D_Mem_Req))
	else begin
		assert_errors++;
		$error("Data cache got a response without the grant");
	end

	a_i_routed: assert property (@(posedge i_Clk) disable iff (!i_Reset_n)
		(|i_I_Mem_Rsp) |-> (i_I_Mem_Req.valid && i_Mem_Req == i_I_Mem_Req))
	else begin
		assert_errors++;
		$error("Instruction cache got a response without the grant");
	end

endmodule

bind mem_arbiter cache_asserts u_cache_asserts (
	.i_Clk(i_Clk),
	.i_Reset_n(i_Reset_n),
	.i_Grant(grant),
	.i_D_Mem_Req(i_D_Mem_Req),
	.i_I_Mem_Req(i_I_Mem_Req),
	.i_Mem_Req(o_Mem_Req),
	.i_D_Mem_Rsp(o_D_Mem_Rsp),
	.i_I_Mem_Rsp(o_I_Mem_Rsp)
);

`default_nettype wire

//--- sim/tb_cache_subsystem.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_macros.svh"

// Data-file driven testbench for the two caches and the memory arbiter
module tb_cache_subsystem;

	localparam int TIMEOUT = 200; // Cycles per wait
	localparam int SWEEP_TIMEOUT = 1000; // Tag store clear takes 512

	logic i_Clk = 1'b0;
	logic i_Reset_n;
	cache_pkg::cache_req_t i_D_Req;
	cache_pkg::cache_req_t i_I_Req;
	cache_pkg::cache_rsp_t o_D_Rsp;
	cache_pkg::cache_rsp_t o_I_Rsp;
	cache_pkg::mem_req_t o_Mem_Req;
	cache_pkg::mem_rsp_t i_Mem_Rsp = '0;

	logic [`CACHE_DATA_W-1:0] mem_store [logic [`CACHE_ADDR_W-1:0]]; // Written words only
	logic [`CACHE_TAG_W-1:0] d_tags [logic [`CACHE_INDEX_W-1:0]]; // Lines the D cache holds
	logic [`CACHE_TAG_W-1:0] i_tags [logic [`CACHE_INDEX_W-1:0]]; // Lines the I cache holds
	logic [31:0] rng = 32'h4cec3dba;
	logic [1:0] beat = '0; // Word within the line transfer
	logic [1:0] gap = '0; // Idle cycles before next beat
	int pass_count = 0;
	int fail_count = 0;

	always #4 i_Clk = ~i_Clk; // 8 ns period

	cache_subsystem_top i_dut (
		.i_Clk(i_Clk),
		.i_Reset_n(i_Reset_n),
		.i_D_Req(i_D_Req),
		.o_D_Rsp(o_D_Rsp),
		.i_I_Req(i_I_Req),
		.o_I_Rsp(o_I_Rsp),
		.o_Mem_Req(o_Mem_Req),
		.i_Mem_Rsp(i_Mem_Rsp)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Unwritten words read back as their own address with a fixed pattern
	function automatic logic [`CACHE_DATA_W-1:0] mem_word(input logic [`CACHE_ADDR_W-1:0] a);
		if (mem_store.exists(a))
			return mem_store[a];
		return 32'(a) ^ 32'hA5A50000;
	endfunction

	// Expected hit from the lines loaded so far
	// Every request leaves its own line loaded
	function automatic bit lookup_line(input bit is_i, input logic [`CACHE_ADDR_W-1:0] addr);
		logic [`CACHE_INDEX_W-1:0] idx;
		logic [`CACHE_TAG_W-1:0] tag;
		bit found;
		idx = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
		tag = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
		found = 1'b0;
		if (is_i) begin
			if (i_tags.exists(idx))
				found = (i_tags[idx] == tag);
			i_tags[idx] = tag;
		end else begin
			if (d_tags.exists(idx))
				found = (d_tags[idx] == tag);
			d_tags[idx] = tag;
		end
		return found;
	endfunction

	// Memory model, one beat per cycle plus random gaps
	always @(negedge i_Clk) begin
		logic [`CACHE_ADDR_W-1:0] a;
		i_Mem_Rsp = '0;
		if (!i_Reset_n || !o_Mem_Req.valid) begin
			beat = '0;
			gap = '0;
		end else if (gap != 2'd0) begin
			gap = gap - 2'd1;
		end else begin
			a = o_Mem_Req.addr + {{(`CACHE_ADDR_W-2){1'b0}}, beat};
			if (o_Mem_Req.read_write_n) begin
				i_Mem_Rsp.valid = 1'b1;
				i_Mem_Rsp.rdata = mem_word(a);
			end else begin
				mem_store[a] = o_Mem_Req.wdata; // Write-back word
				i_Mem_Rsp.data_read = 1'b1;
			end
			i_Mem_Rsp.last = (beat == 2'd3);
			beat = beat + 2'd1; // Wraps for the fill after a write-out
			rng = xorshift32(rng);
			gap = rng[1:0];
		end
	end

	task automatic set_request(input bit is_i, input cache_pkg::cache_req_t req);
		if (is_i)
			i_I_Req = req;
		else
			i_D_Req = req;
	endtask

	function automatic cache_pkg::cache_rsp_t port_rsp(input bit is_i);
		return is_i ? o_I_Rsp : o_D_Rsp;
	endfunction

	// One request on one port, acceptance then result
	task automatic run_request(
		input bit is_i,
		input logic [7:0] op,
		input logic [`CACHE_ADDR_W-1:0] addr,
		input logic [`CACHE_DATA_W-1:0] wdata,
		input logic [`CACHE_DATA_W-1:0] expd,
		output bit ok
	);
		cache_pkg::cache_req_t req;
		cache_pkg::cache_rsp_t rsp;
		int waited;
		bit exp_hit;
		req.valid = 1'b1;
		req.read_write_n = (op != "W");
		req.addr = addr;
		req.wdata = wdata;
		ok = 1'b1;
		waited = 0;
		exp_hit = lookup_line(is_i, addr);
		@(negedge i_Clk);
		set_request(is_i, req);
		rsp = port_rsp(is_i); // Ready comes from registers only
		while (!rsp.ready && waited < TIMEOUT) begin
			@(negedge i_Clk);
			waited++;
			rsp = port_rsp(is_i);
		end
		if (!rsp.ready) begin
			$display("Timeout: %s port request to %h was never accepted", is_i ? "I" : "D", addr);
			ok = 1'b0;
			set_request(is_i, '0);
		end else begin
			@(negedge i_Clk); // Taken on the edge just passed
			set_request(is_i, '0);
			waited = 0;
			rsp = port_rsp(is_i);
			// Only a hit answers in the lookup cycle
			if (rsp.valid !== exp_hit) begin
				$display("FAIL time %0t %s.valid expected %b actual %b", $time,
					is_i ? "o_I_Rsp" : "o_D_Rsp", exp_hit, rsp.valid);
				ok = 1'b0;
			end
			while (!rsp.valid && waited < TIMEOUT) begin
				@(negedge i_Clk);
				waited++;
				rsp = port_rsp(is_i);
			end
			if (!rsp.valid) begin
				$display("Timeout: %s port request to %h never returned a result",
					is_i ? "I" : "D", addr);
				ok = 1'b0;
			end else if (req.read_write_n && rsp.rdata !== expd) begin
				$display("FAIL time %0t %s.rdata expected %h actual %h", $time,
					is_i ? "o_I_Rsp" : "o_D_Rsp", expd, rsp.rdata);
				ok = 1'b0;
			end
		end
	endtask

	initial begin
		int fd;
		int ch;
		int n;
		int test_num;
		int waited;
		logic [7:0] port;
		logic [7:0] op;
		logic [`CACHE_ADDR_W-1:0] addr;
		logic [`CACHE_DATA_W-1:0] wdata;
		logic [`CACHE_DATA_W-1:0] expd;
		logic [`CACHE_ADDR_W-1:0] fetch_addr;
		logic [`CACHE_DATA_W-1:0] fetch_expd;
		bit ok_d;
		bit ok_i;
		$timeformat(-9, 1, " ns", 0);
		i_Reset_n = 1'b0;
		i_D_Req = '0;
		i_I_Req = '0;
		test_num = 0;
		repeat (16) @(negedge i_Clk);
		i_Reset_n = 1'b1;
		waited = 0;
		// Both tag stores sweep before taking requests
		while (!(o_D_Rsp.ready && o_I_Rsp.ready) && waited < SWEEP_TIMEOUT) begin
			@(negedge i_Clk);
			waited++;
		end
		if (!(o_D_Rsp.ready && o_I_Rsp.ready)) begin
			$display("Timeout: caches did not become ready after reset");
			fail_count++;
		end
		fd = $fopen("sim/cache_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file sim/cache_tests.txt");
			fail_count++;
		end else begin
			ch = $fgetc(fd);
			while (ch != -1) begin
				port = 8'(ch);
				if (port == "#") begin
					while (ch != -1 && 8'(ch) != 8'h0a) begin
						ch = $fgetc(fd); // Skip comment line
					end
				end else if (port == "D" || port == "I" || port == "B") begin
					n = $fscanf(fd, " %c %h %h %h", op, addr, wdata, expd);
					if (port == "B")
						n += $fscanf(fd, " %h %h", fetch_addr, fetch_expd);
					test_num++;
					ok_d = 1'b1;
					ok_i = 1'b1;
					if (n != ((port == "B") ? 6 : 4)) begin
						$display("Test %0d: line in the test file could not be read", test_num);
						ok_d = 1'b0;
					end else if (port == "B") begin
						fork // Same-cycle requests on both ports
							run_request(1'b0, op, addr, wdata, expd, ok_d);
							run_request(1'b1, "R", fetch_addr, '0, fetch_expd, ok_i);
						join
					end else begin
						run_request(port == "I", op, addr, wdata, expd, ok_d);
					end
					if (ok_d && ok_i) begin
						pass_count++;
						$display("Test %0d: %c %c %h passed", test_num, port, op, addr);
					end else begin
						fail_count++;
						$display("Test %0d: %c %c %h failed", test_num, port, op, addr);
					end
				end
				if (ch != -1)
					ch = $fgetc(fd);
			end
			$fclose(fd);
		end
		$display("Tests passed: %0d, failed: %0d, assertion errors: %0d", pass_count,
			fail_count, i_dut.u_mem_arbiter.u_cache_asserts.assert_errors);
		if (fail_count == 0 && pass_count > 0 &&
				i_dut.u_mem_arbiter.u_cache_asserts.assert_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/cache_tests.txt
# port(D/I/B) op(R/W) word_addr wdata expected; expected unchecked on writes
# B lines add the I port fetch: fetch_addr fetch_expected, issued in the same cycle
D R 000100 00000000 A5A50100
D R 000100 00000000 A5A50100
D R 000102 00000000 A5A50102
D W 000101 11111111 00000000
D R 000101 00000000 11111111
D R 000100 00000000 A5A50100
D R 000103 00000000 A5A50103
D R 000900 00000000 A5A50900
D R 000101 00000000 11111111
D R 000102 00000000 A5A50102
D W 002205 CAFEF00D 00000000
D R 002205 00000000 CAFEF00D
D R 002204 00000000 A5A52204
D R 002207 00000000 A5A52207
D R 002A05 00000000 A5A52A05
D R 002205 00000000 CAFEF00D
D R 002206 00000000 A5A52206
I R 004000 00000000 A5A54000
I R 004001 00000000 A5A54001
I R 004003 00000000 A5A54003
I R 000101 00000000 11111111
B R 006010 00000000 A5A56010 008020 A5A58020
B W 006011 22222222 00000000 008022 A5A58022
D R 006011 00000000 22222222
B W 00A030 12345678 00000000 00C040 A5A5C040
D R 00A030 00000000 12345678
D R 00A031 00000000 A5A5A031
I R 00C043 00000000 A5A5C043

//--- vlog.f
+incdir+include
src/cache_pkg.sv
src/cache_sram.sv
src/d_cache.sv
src/i_cache.sv
src/mem_arbiter.sv
src/cache_subsystem_top.sv
sim/cache_asserts.sv
sim/tb_cache_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP := tb_cache_subsystem
FILELIST := vlog.f
VFLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR := obj_dir
LOG := sim.log
SIM_ARGS := +verilator+error+limit+100
PASS_MSG := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
